// ==== bench/tb_link_tasks.svh ====
`ifndef TB_LINK_TASKS_SVH
`define TB_LINK_TASKS_SVH

// ========================================
// Helpers
// ========================================
task automatic check_value(input string test_name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (actual !== expected) begin
        $display("FAIL %s: expected %h, actual %h", test_name, expected, actual);
        report_failure();
    end
endtask

// DatInStatus layout: overflow, count, mode_valid, access_mode
function automatic logic [63:0] status_word(input logic [3:0] mode, input logic valid,
                                            input logic [4:0] cnt, input logic ovf);
    return {53'd0, ovf, cnt, valid, mode};
endfunction

function automatic logic [63:0] read_word(input logic empty, input logic [15:0] word);
    return {47'd0, empty, word};
endfunction

// Start bit, then MSB first; called and left on a falling edge
task automatic send_msg(input logic [7:0] msg_type, input logic [55:0] arg);
    logic [`SD_MSG_LEN-1:0] m;
    m = {msg_type, arg};
    msg_in = 1'b1;
    @(negedge sd_datInWrite_clk);
    for (int i = `SD_MSG_LEN - 1; i >= 0; i--) begin
        msg_in = m[i];
        @(negedge sd_datInWrite_clk);
    end
    msg_in = 1'b0;
endtask

task automatic get_resp(output logic [63:0] r);
    int waited;
    waited = 0;
    while (!resp_oe) begin
        if (waited == RESP_WAIT) begin
            $display("No response appeared within %0d cycles", RESP_WAIT);
            report_failure();
        end
        waited++;
        @(negedge sd_datInWrite_clk);
    end
    for (int i = `SD_RESP_LEN - 1; i >= 0; i--) begin
        if (!resp_oe) begin
            $display("resp_oe dropped before bit %0d of the response", i);
            report_failure();
        end
        r[i] = resp_out;    // Mid-cycle sample
        @(negedge sd_datInWrite_clk);
    end
    if (resp_oe) begin
        $display("resp_oe stayed high after the 64 response bits");
        report_failure();
    end
endtask

// Message without response: resp_oe must stay low, bad_cmd cycles are counted
task automatic watch_quiet(input string test_name, output int bad_cycles);
    bad_cycles = 0;
    repeat (QUIET_CYCLES) begin
        if (resp_oe) begin
            $display("%s: a response started for a message that has none", test_name);
            report_failure();
        end
        if (bad_cmd) begin
            bad_cycles++;
        end
        @(negedge sd_datInWrite_clk);
    end
endtask

task automatic push_words(input int n);
    logic [31:0] rnd;
    for (int i = 0; i < n; i++) begin
        rnd         = $random(seed);
        pushed[i]   = rnd[15:0];
        datin_valid = 1'b1;
        datin_word  = rnd[15:0];
        @(negedge sd_datInWrite_clk);
    end
    datin_valid = 1'b0;
    datin_word  = '0;
endtask

// ========================================
// Directed tests
// ========================================
task automatic test_reset_state();
    logic [63:0] r;
    check_value("reset_led", 64'd0, 64'(led));
    check_value("reset_resp_oe", 64'd0, 64'(resp_oe));
    check_value("reset_bad_cmd", 64'd0, 64'(bad_cmd));
    send_msg(TYPE_DATIN_STATUS, '0);
    get_resp(r);
    check_value("reset_status", 64'd0, r);
endtask

task automatic test_led_and_nop();
    logic [63:0] rnd;
    int          bad;
    rnd = '0;
    repeat (4) begin
        rnd = {$random(seed), $random(seed)};
        send_msg(TYPE_LED_SET, rnd[55:0]);
        watch_quiet("led_set", bad);
        check_value("led_set", 64'(rnd[3:0]), 64'(led));
        check_value("led_set_bad_cmd", 64'd0, 64'(bad));
    end
    send_msg(TYPE_NOP, ~rnd[55:0]);     // LED must not follow a Nop
    watch_quiet("nop", bad);
    check_value("nop_led", 64'(rnd[3:0]), 64'(led));
    check_value("nop_bad_cmd", 64'd0, 64'(bad));
endtask

task automatic test_echo();
    logic [63:0] rnd;
    logic [63:0] r;
    repeat (4) begin
        rnd = {$random(seed), $random(seed)};
        send_msg(TYPE_ECHO, rnd[55:0]);
        get_resp(r);
        check_value("echo", {rnd[55:0], 8'h00}, r);
    end
endtask

// One full block into a 16-deep FIFO: overflow, then drain in order
task automatic test_datin_fifo();
    logic [63:0] r;
    push_words(`SD_BLOCK_WORDS);
    send_msg(TYPE_DATIN_STATUS, '0);
    get_resp(r);
    check_value("datin_status",
                status_word(pushed[`SD_CMD6_WORD_IDX][11:8], 1'b1, 5'd16, 1'b1), r);
    for (int i = 0; i < `SD_FIFO_DEPTH; i++) begin
        send_msg(TYPE_DATIN_READ, '0);
        get_resp(r);
        check_value("datin_read", read_word(1'b0, pushed[i]), r);
    end
    send_msg(TYPE_DATIN_READ, '0);
    get_resp(r);
    check_value("datin_read_empty", read_word(1'b1, 16'h0000), r);
endtask

task automatic test_clear_and_bad_type();
    logic [63:0] r;
    int          bad;
    send_msg(TYPE_DATIN_RESET, '0);
    watch_quiet("datin_reset", bad);
    check_value("datin_reset_bad_cmd", 64'd0, 64'(bad));
    send_msg(TYPE_DATIN_STATUS, '0);
    get_resp(r);
    check_value("status_after_clear", 64'd0, r);
    send_msg(TYPE_UNKNOWN, '0);
    watch_quiet("unknown_type", bad);
    check_value("unknown_type_bad_cmd", 64'd1, 64'(bad));  // A single-cycle strobe
endtask

`endif

// ==== bench/tb_sd_link.sv ====
`timescale 1ns/10ps
`include "sd_link_settings.svh"

module tb_sd_link;

    localparam int CLK_PERIOD   = 4;
    localparam int RESP_WAIT    = 10;   // Cycles allowed before resp_oe rises
    localparam int QUIET_CYCLES = 8;    // Window watched after a message without response

    // 60 messages of 140 cycles, 200 data-in cycles, 50% margin
    localparam int WATCHDOG_CYCLES = (60 * 140 + 200) * 3 / 2;

    // Message type codes
    localparam logic [7:0] TYPE_NOP          = 8'h00;
    localparam logic [7:0] TYPE_LED_SET      = 8'h02;
    localparam logic [7:0] TYPE_DATIN_RESET  = 8'h05;
    localparam logic [7:0] TYPE_ECHO         = 8'h81;
    localparam logic [7:0] TYPE_DATIN_STATUS = 8'h83;
    localparam logic [7:0] TYPE_DATIN_READ   = 8'h84;
    localparam logic [7:0] TYPE_UNKNOWN      = 8'h7F;

    logic                   sd_datInWrite_clk;
    logic                   sd_datInWrite_rst_;
    logic                   msg_in;
    logic                   datin_valid;
    logic [`SD_WORD_W-1:0]  datin_word;
    logic                   resp_out;
    logic                   resp_oe;
    logic [3:0]             led;
    logic                   bad_cmd;

    int                     seed;
    logic [`SD_WORD_W-1:0]  pushed [`SD_BLOCK_WORDS];  // Words sent on the data-in port

    sd_link_top i_dut (
        .sd_datInWrite_clk,
        .sd_datInWrite_rst_,
        .msg_in,
        .datin_valid,
        .datin_word,
        .resp_out,
        .resp_oe,
        .led,
        .bad_cmd
    );

    task automatic report_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    `include "tb_link_tasks.svh"

    // ========================================
    // Clock and watchdog
    // ========================================
    initial begin
        sd_datInWrite_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sd_datInWrite_clk = ~sd_datInWrite_clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sd_datInWrite_clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        report_failure();
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        sd_datInWrite_rst_ = 1'b0;
        msg_in             = 1'b0;
        datin_valid        = 1'b0;
        datin_word         = '0;
        seed               = 32'h9c99_4797;

        repeat (3) @(negedge sd_datInWrite_clk);
        sd_datInWrite_rst_ = 1'b1;
        @(negedge sd_datInWrite_clk);

        test_reset_state();
        test_led_and_nop();
        test_echo();
        test_datin_fifo();
        test_clear_and_bad_type();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== common/sd_datin_pkg.sv ====
`include "sd_link_settings.svh"

package sd_datin_pkg;

    // Width that holds 0 up to a full FIFO
    localparam int FIFO_COUNT_W = $clog2(`SD_FIFO_DEPTH) + 1;

    typedef logic [`SD_WORD_W-1:0] datin_word_t;

    // Status as reported by DatInStatus
    typedef struct packed {
        logic                    overflow;      // Bit 10
        logic [FIFO_COUNT_W-1:0] fifo_count;    // Bits 9:5
        logic                    mode_valid;    // Bit 4
        logic [3:0]              access_mode;   // Bits 3:0
    } datin_status_t;

endpackage

// ==== common/sd_link_settings.svh ====
`ifndef SD_LINK_SETTINGS_SVH
`define SD_LINK_SETTINGS_SVH

// ========================================
// Message link
// ========================================
`define SD_MSG_LEN          64      // Bits per host message
`define SD_RESP_LEN         64      // Bits per response
`define SD_TYPE_LEN         8       // Type field at the top of a message

// ========================================
// SD data-in path
// ========================================
`define SD_WORD_W           16
`define SD_BLOCK_WORDS      32      // 512-bit block
`define SD_CMD6_WORD_IDX    8       // Word carrying the CMD6 access mode
`define SD_FIFO_DEPTH       16      // Power of two

`endif

// ==== common/sd_msg_pkg.sv ====
`include "sd_link_settings.svh"

package sd_msg_pkg;

    localparam int MSG_ARG_LEN  = `SD_MSG_LEN - `SD_TYPE_LEN;
    localparam int MSG_RESP_BIT = `SD_TYPE_LEN - 1;    // Set for types that answer

    // Message types
    typedef enum logic [`SD_TYPE_LEN-1:0] {
        MSG_NOP          = 8'h00,
        MSG_LED_SET      = 8'h02,
        MSG_DATIN_RESET  = 8'h05,
        MSG_ECHO         = 8'h81,
        MSG_DATIN_STATUS = 8'h83,
        MSG_DATIN_READ   = 8'h84
    } msg_type_e;

    typedef struct packed {
        msg_type_e              msg_type;   // Top byte, first on the wire
        logic [MSG_ARG_LEN-1:0] arg;
    } msg_t;

    typedef logic [`SD_RESP_LEN-1:0] resp_t;

    // Echo answer layout
    typedef struct packed {
        logic [MSG_ARG_LEN-1:0] arg;
        logic [`SD_TYPE_LEN-1:0] zero;
    } resp_echo_t;

    // DatInRead answer layout
    typedef struct packed {
        logic [`SD_RESP_LEN-`SD_WORD_W-2:0] zero;
        logic                                empty;
        logic [`SD_WORD_W-1:0]               word;
    } resp_read_t;

endpackage

// ==== compile.f ====
+incdir+common
+incdir+bench
common/sd_msg_pkg.sv
common/sd_datin_pkg.sv
hw/msg_rx.sv
hw/resp_tx.sv
hw/cmd_exec.sv
hw/datin/cmd6_capture.sv
hw/datin/datin_fifo.sv
hw/sd_link_top.sv
bench/tb_sd_link.sv

// ==== hw/cmd_exec.sv ====
`timescale 1ns/10ps
`include "sd_link_settings.svh"

module cmd_exec
    import sd_msg_pkg::*;
    import sd_datin_pkg::*;
(
    input  logic          sd_datInWrite_clk,
    input  logic          sd_datInWrite_rst_,
    input  logic          msg_valid,
    input  msg_t          msg,
    input  datin_status_t status,
    input  datin_word_t   fifo_head,
    output logic          resp_start,
    output resp_t         resp,
    output logic          fifo_pop,
    output logic          datin_clear,
    output logic [3:0]    led,
    output logic          bad_cmd
);

    logic [`SD_TYPE_LEN-1:0] type_bits;
    logic                    type_known;
    logic                    fifo_empty;
    resp_echo_t              echo_d;
    resp_read_t              read_d;
    resp_t                   resp_d;

    assign type_bits  = msg.msg_type;
    assign fifo_empty = (status.fifo_count == '0);

    // ========================================
    // Decode and response build
    // ========================================
    always_comb begin
        echo_d.arg   = msg.arg;
        echo_d.zero  = '0;
        read_d.zero  = '0;
        read_d.empty = fifo_empty;
        read_d.word  = fifo_empty ? '0 : fifo_head;    // Word 0 when nothing queued
    end

    always_comb begin
        type_known = 1'b1;
        resp_d     = '0;
        case (msg.msg_type)
            MSG_NOP, MSG_LED_SET, MSG_DATIN_RESET: begin
            end
            MSG_ECHO:         resp_d = resp_t'(echo_d);
            MSG_DATIN_STATUS: resp_d[$bits(datin_status_t)-1:0] = status;
            MSG_DATIN_READ:   resp_d = resp_t'(read_d);
            default:          type_known = 1'b0;
        endcase
    end

    // ========================================
    // Registers and strobes
    // ========================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            resp_start  <= 1'b0;
            fifo_pop    <= 1'b0;
            datin_clear <= 1'b0;
            bad_cmd     <= 1'b0;
            led         <= '0;
        end else begin
            resp_start  <= 1'b0;
            fifo_pop    <= 1'b0;
            datin_clear <= 1'b0;
            bad_cmd     <= 1'b0;
            if (msg_valid) begin
                resp_start <= type_known && type_bits[MSG_RESP_BIT];
                bad_cmd    <= !type_known;
                if (msg.msg_type == MSG_LED_SET) begin
                    led <= msg.arg[3:0];
                end
                if (msg.msg_type == MSG_DATIN_RESET) begin
                    datin_clear <= 1'b1;
                end
                if (msg.msg_type == MSG_DATIN_READ) begin
                    fifo_pop <= !fifo_empty;    // Head already latched into resp
                end
            end
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if (msg_valid) begin
            resp <= resp_d;
        end
    end

endmodule

// ==== hw/datin/cmd6_capture.sv ====
`timescale 1ns/10ps
`include "sd_link_settings.svh"

module cmd6_capture
    import sd_datin_pkg::*;
(
    input  logic        sd_datInWrite_clk,
    input  logic        sd_datInWrite_rst_,
    input  logic        datin_valid,
    input  datin_word_t datin_word,
    input  logic        datin_clear,
    output logic [3:0]  access_mode,
    output logic        mode_valid
);

    localparam int CNT_W = $clog2(`SD_BLOCK_WORDS);

    logic [CNT_W-1:0] word_idx;     // Position within the current block
    logic             mode_word;

    assign mode_word = datin_valid && (word_idx == CNT_W'(`SD_CMD6_WORD_IDX));

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_idx    <= '0;
            access_mode <= '0;
            mode_valid  <= 1'b0;
        end else if (datin_clear) begin
            word_idx    <= '0;
            access_mode <= '0;
            mode_valid  <= 1'b0;
        end else begin
            if (datin_valid) begin
                word_idx <= word_idx + 1'b1;    // Wraps at the block boundary
            end
            if (mode_word) begin
                access_mode <= datin_word[11:8];
                mode_valid  <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/datin/datin_fifo.sv ====
`timescale 1ns/10ps
`include "sd_link_settings.svh"

module datin_fifo
    import sd_datin_pkg::*;
#(
    parameter int DEPTH = `SD_FIFO_DEPTH
) (
    input  logic        sd_datInWrite_clk,
    input  logic        sd_datInWrite_rst_,
    input  logic        push,
    input  datin_word_t wdata,
    input  logic        pop,
    input  logic        clear,
    output datin_word_t head,
    output logic [4:0]  count,
    output logic        empty,
    output logic        overflow
);

    localparam int AW = $clog2(DEPTH);

    datin_word_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          full;
    logic          do_push;
    logic          do_pop;

    assign empty   = (count == '0);
    assign full    = (count == 5'(DEPTH));
    assign do_push = push && !full && !clear;
    assign do_pop  = pop && !empty && !clear;
    assign head    = mem[rd_ptr];    // Show-ahead

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else if (clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && full) overflow <= 1'b1;    // Word dropped
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // The reader looks at the count a cycle before it pops
    assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        pop |-> !empty);

endmodule

// ==== hw/msg_rx.sv ====
`timescale 1ns/10ps
`include "sd_link_settings.svh"

module msg_rx
    import sd_msg_pkg::*;
(
    input  logic sd_datInWrite_clk,
    input  logic sd_datInWrite_rst_,
    input  logic msg_in,
    output logic msg_valid,
    output msg_t msg
);

    localparam int CNT_W = $clog2(`SD_MSG_LEN);

    typedef enum logic {
        RX_IDLE,
        RX_SHIFT
    } rx_state_e;

    rx_state_e              state;
    logic [CNT_W-1:0]       bit_cnt;    // Bits still to come, minus one
    logic [`SD_MSG_LEN-2:0] shift_q;
    logic                   last_bit;

    assign last_bit = (state == RX_SHIFT) && (bit_cnt == '0);

    // ========================================
    // Framing
    // ========================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state     <= RX_IDLE;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= last_bit;
            case (state)
                RX_IDLE: begin
                    if (msg_in) begin   // Start bit
                        state   <= RX_SHIFT;
                        bit_cnt <= CNT_W'(`SD_MSG_LEN - 1);
                    end
                end
                RX_SHIFT: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    if (bit_cnt == '0) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // MSB arrives first
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state == RX_SHIFT) begin
            shift_q <= {shift_q[`SD_MSG_LEN-3:0], msg_in};
        end
        if (last_bit) begin
            msg <= msg_t'({shift_q, msg_in});
        end
    end

    // A start bit always separates two messages
    assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        msg_valid |=> !msg_valid);

endmodule

// ==== hw/resp_tx.sv ====
`timescale 1ns/10ps
`include "sd_link_settings.svh"

module resp_tx
    import sd_msg_pkg::*;
(
    input  logic  sd_datInWrite_clk,
    input  logic  sd_datInWrite_rst_,
    input  logic  resp_start,
    input  resp_t resp,
    output logic  resp_out,
    output logic  resp_oe
);

    localparam int CNT_W = $clog2(`SD_RESP_LEN);

    logic [CNT_W-1:0] bit_cnt;
    resp_t            shift_q;

    // Zeros shift in behind the data, so the line idles low
    assign resp_out = shift_q[`SD_RESP_LEN-1];

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            resp_oe <= 1'b0;
            bit_cnt <= '0;
            shift_q <= '0;
        end else if (resp_start) begin
            resp_oe <= 1'b1;
            bit_cnt <= CNT_W'(`SD_RESP_LEN - 1);
            shift_q <= resp;
        end else if (resp_oe) begin
            bit_cnt <= bit_cnt - 1'b1;
            shift_q <= shift_q << 1;
            if (bit_cnt == '0) begin
                resp_oe <= 1'b0;    // Last bit on the line
            end
        end
    end

    // Host waits for the previous response before sending again
    assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        resp_start |-> !resp_oe);

endmodule

// ==== hw/sd_link_top.sv ====
`timescale 1ns/10ps
`include "sd_link_settings.svh"

module sd_link_top
    import sd_msg_pkg::*;
    import sd_datin_pkg::*;
(
    input  logic        sd_datInWrite_clk,
    input  logic        sd_datInWrite_rst_,
    input  logic        msg_in,
    input  logic        datin_valid,
    input  datin_word_t datin_word,
    output logic        resp_out,
    output logic        resp_oe,
    output logic [3:0]  led,
    output logic        bad_cmd
);

    logic          msg_valid;
    msg_t          msg;
    logic          resp_start;
    resp_t         resp;
    logic          fifo_pop;
    logic          datin_clear;
    datin_word_t   fifo_head;
    logic [4:0]    fifo_count;
    logic          fifo_overflow;
    logic [3:0]    access_mode;
    logic          mode_valid;
    datin_status_t status;

    assign status.overflow    = fifo_overflow;
    assign status.fifo_count  = fifo_count;
    assign status.mode_valid  = mode_valid;
    assign status.access_mode = access_mode;

    // ========================================
    // Message side
    // ========================================
    msg_rx i_msg_rx (.sd_datInWrite_clk, .sd_datInWrite_rst_, .msg_in, .msg_valid, .msg);

    cmd_exec i_cmd_exec (
        .sd_datInWrite_clk, .sd_datInWrite_rst_,
        .msg_valid, .msg, .status, .fifo_head,
        .resp_start, .resp, .fifo_pop, .datin_clear, .led, .bad_cmd
    );

    resp_tx i_resp_tx (.sd_datInWrite_clk, .sd_datInWrite_rst_, .resp_start, .resp,
        .resp_out, .resp_oe);

    // ========================================
    // SD data-in side
    // ========================================
    cmd6_capture i_cmd6_capture (
        .sd_datInWrite_clk, .sd_datInWrite_rst_,
        .datin_valid, .datin_word, .datin_clear, .access_mode, .mode_valid
    );

    // Empty is derived from the status count inside cmd_exec
    datin_fifo #(.DEPTH(`SD_FIFO_DEPTH)) i_datin_fifo (
        .sd_datInWrite_clk, .sd_datInWrite_rst_,
        .push(datin_valid), .wdata(datin_word), .pop(fifo_pop), .clear(datin_clear),
        .head(fifo_head), .count(fifo_count), .empty(), .overflow(fifo_overflow)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the sd_link testbench with Verilator
# Exit status is nonzero when the build fails or the testbench reports failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_sd_link \
    -f compile.f \
    -o tb_sd_link_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_sd_link_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
